// ==== src/cdc_payload_pkg.sv ====
package cdc_payload_pkg;

  // One word of the sample stream.
  typedef struct packed {
    logic [15:0] data;
    logic [3:0]  channel;
    logic        last;      // Closes a frame.
  } sample_t;

  // One word of the control stream.
  typedef struct packed {
    logic [2:0] opcode;
    logic [7:0] arg;
  } ctrl_msg_t;

endpackage

// ==== src/fifo_status_pkg.sv ====
package fifo_status_pkg;

  localparam int PTR_MAX_W = 8;              // Widest pointer the converters handle.

  typedef logic [PTR_MAX_W-1:0] ptr_word_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  // Narrower pointers are zero-extended by the caller.
  function automatic ptr_word_t bin2gray(input ptr_word_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_word_t gray2bin(input ptr_word_t gray);
    ptr_word_t bin;
    bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
    for (int i = PTR_MAX_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];           // Prefix XOR from the top.
    end
    return bin;
  endfunction

endpackage

// ==== src/dual_port_ram.sv ====
`timescale 1ns/10ps

module dual_port_ram #(
  parameter type payload_t  = logic [7:0],
  parameter int  ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  payload_t              wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output payload_t              rd_data
);

  payload_t mem [2**ADDR_WIDTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, word holds until the next enabled read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== src/wr_ptr_ctrl.sv ====
`timescale 1ns/10ps

module wr_ptr_ctrl #(
  parameter int ADDR_WIDTH = 4,
  parameter int AFULL      = 12
) (
  input  logic                        wr_clk,
  input  logic                        wr_rst_n,
  input  logic                        wr_en,
  input  logic [ADDR_WIDTH:0]         rd_gray,     // Read domain.
  output logic                        wr_accept,
  output logic [ADDR_WIDTH-1:0]       wr_addr,
  output logic [ADDR_WIDTH:0]         wr_gray,
  output fifo_status_pkg::wr_status_t wr_status
);

  import fifo_status_pkg::*;

  localparam logic [ADDR_WIDTH:0] PTR_ONE   = {{ADDR_WIDTH{1'b0}}, 1'b1};
  localparam logic [ADDR_WIDTH:0] AFULL_LVL = AFULL[ADDR_WIDTH:0];

  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_s1;
  logic [ADDR_WIDTH:0] rd_gray_s2;
  logic [ADDR_WIDTH:0] rd_bin_sync;
  logic [ADDR_WIDTH:0] used_nxt;
  ptr_word_t           gray_word;
  ptr_word_t           bin_word;

  assign wr_accept = wr_en & ~wr_status.full;
  assign wr_addr   = wr_bin[ADDR_WIDTH-1:0];

  always_comb begin
    if (wr_accept) begin
      wr_bin_nxt = wr_bin + PTR_ONE;
    end else begin
      wr_bin_nxt = wr_bin;
    end
  end

  assign gray_word   = bin2gray(ptr_word_t'(wr_bin_nxt));
  assign wr_gray_nxt = gray_word[ADDR_WIDTH:0];

  assign bin_word    = gray2bin(ptr_word_t'(rd_gray_s2));
  assign rd_bin_sync = bin_word[ADDR_WIDTH:0];
  assign used_nxt    = wr_bin_nxt - rd_bin_sync;   // May overstate, never understates.

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
      wr_status  <= '{full: 1'b0, afull: 1'b0};
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= wr_gray_nxt;
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
      // Full when a whole lap ahead, top two Gray bits flipped.
      wr_status.full <= (wr_gray_nxt == {~rd_gray_s2[ADDR_WIDTH:ADDR_WIDTH-1],
                                          rd_gray_s2[ADDR_WIDTH-2:0]});
      wr_status.afull <= (used_nxt >= AFULL_LVL);
    end
  end

endmodule

// ==== src/rd_ptr_ctrl.sv ====
`timescale 1ns/10ps

module rd_ptr_ctrl #(
  parameter int ADDR_WIDTH = 4,
  parameter int AEMPTY     = 2
) (
  input  logic                        rd_clk,
  input  logic                        rd_rst_n,
  input  logic                        rd_en,
  input  logic [ADDR_WIDTH:0]         wr_gray,     // Write domain.
  output logic                        rd_accept,
  output logic [ADDR_WIDTH-1:0]       rd_addr,
  output logic [ADDR_WIDTH:0]         rd_gray,
  output fifo_status_pkg::rd_status_t rd_status
);

  import fifo_status_pkg::*;

  localparam logic [ADDR_WIDTH:0] PTR_ONE    = {{ADDR_WIDTH{1'b0}}, 1'b1};
  localparam logic [ADDR_WIDTH:0] AEMPTY_LVL = AEMPTY[ADDR_WIDTH:0];

  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_gray_s1;
  logic [ADDR_WIDTH:0] wr_gray_s2;
  logic [ADDR_WIDTH:0] wr_bin_sync;
  logic [ADDR_WIDTH:0] used_nxt;
  ptr_word_t           gray_word;
  ptr_word_t           bin_word;

  assign rd_accept = rd_en & ~rd_status.empty;
  assign rd_addr   = rd_bin[ADDR_WIDTH-1:0];

  always_comb begin
    if (rd_accept) begin
      rd_bin_nxt = rd_bin + PTR_ONE;
    end else begin
      rd_bin_nxt = rd_bin;
    end
  end

  assign gray_word   = bin2gray(ptr_word_t'(rd_bin_nxt));
  assign rd_gray_nxt = gray_word[ADDR_WIDTH:0];

  assign bin_word    = gray2bin(ptr_word_t'(wr_gray_s2));
  assign wr_bin_sync = bin_word[ADDR_WIDTH:0];
  assign used_nxt    = wr_bin_sync - rd_bin_nxt;   // Understates while writes are in flight.

  // Comes out of reset empty.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
      rd_status  <= '{empty: 1'b1, aempty: 1'b1};
    end else begin
      rd_bin           <= rd_bin_nxt;
      rd_gray          <= rd_gray_nxt;
      wr_gray_s1       <= wr_gray;
      wr_gray_s2       <= wr_gray_s1;
      rd_status.empty  <= (rd_gray_nxt == wr_gray_s2);
      rd_status.aempty <= (used_nxt <= AEMPTY_LVL);
    end
  end

endmodule

// ==== src/async_fifo.sv ====
`timescale 1ns/10ps

module async_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16,          // Power of two.
  parameter int  AFULL     = 12,
  parameter int  AEMPTY    = 2
) (
  input  logic                        wr_clk,
  input  logic                        wr_rst_n,
  input  logic                        wr_en,
  input  payload_t                    wr_data,
  output fifo_status_pkg::wr_status_t wr_status,
  input  logic                        rd_clk,
  input  logic                        rd_rst_n,
  input  logic                        rd_en,
  output payload_t                    rd_data,
  output fifo_status_pkg::rd_status_t rd_status
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  logic                  wr_accept;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH:0]   wr_gray;
  logic                  rd_accept;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [ADDR_WIDTH:0]   rd_gray;

  wr_ptr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .AFULL      (AFULL)
  ) i_wr_ptr_ctrl (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .rd_gray   (rd_gray),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_gray   (wr_gray),
    .wr_status (wr_status)
  );

  rd_ptr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .AEMPTY     (AEMPTY)
  ) i_rd_ptr_ctrl (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .wr_gray   (wr_gray),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_gray   (rd_gray),
    .rd_status (rd_status)
  );

  dual_port_ram #(
    .payload_t  (payload_t),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_accept),       // Only accepted writes reach the array.
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_accept),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// ==== src/cdc_bridge_top.sv ====
`timescale 1ns/10ps

module cdc_bridge_top #(
  parameter int SAMPLE_DEPTH  = 16,
  parameter int SAMPLE_AFULL  = 12,
  parameter int SAMPLE_AEMPTY = 2,
  parameter int CTRL_DEPTH    = 4,
  parameter int CTRL_AFULL    = 3,
  parameter int CTRL_AEMPTY   = 1
) (
  input  logic                        wr_clk,
  input  logic                        wr_rst_n,
  input  logic                        rd_clk,
  input  logic                        rd_rst_n,

  input  logic                        sample_wr_en,
  input  cdc_payload_pkg::sample_t    sample_wr_data,
  output fifo_status_pkg::wr_status_t sample_wr_status,
  input  logic                        sample_rd_en,
  output cdc_payload_pkg::sample_t    sample_rd_data,
  output fifo_status_pkg::rd_status_t sample_rd_status,

  input  logic                        ctrl_wr_en,
  input  cdc_payload_pkg::ctrl_msg_t  ctrl_wr_data,
  output fifo_status_pkg::wr_status_t ctrl_wr_status,
  input  logic                        ctrl_rd_en,
  output cdc_payload_pkg::ctrl_msg_t  ctrl_rd_data,
  output fifo_status_pkg::rd_status_t ctrl_rd_status
);

  import cdc_payload_pkg::*;

  async_fifo #(
    .payload_t (sample_t),
    .DEPTH     (SAMPLE_DEPTH),
    .AFULL     (SAMPLE_AFULL),
    .AEMPTY    (SAMPLE_AEMPTY)
  ) i_sample_fifo (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (sample_wr_en),
    .wr_data   (sample_wr_data),
    .wr_status (sample_wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (sample_rd_en),
    .rd_data   (sample_rd_data),
    .rd_status (sample_rd_status)
  );

  // Slow message path, shallow on purpose.
  async_fifo #(
    .payload_t (ctrl_msg_t),
    .DEPTH     (CTRL_DEPTH),
    .AFULL     (CTRL_AFULL),
    .AEMPTY    (CTRL_AEMPTY)
  ) i_ctrl_fifo (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (ctrl_wr_en),
    .wr_data   (ctrl_wr_data),
    .wr_status (ctrl_wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (ctrl_rd_en),
    .rd_data   (ctrl_rd_data),
    .rd_status (ctrl_rd_status)
  );

endmodule

// ==== dv/async_fifo_properties.sv ====
`timescale 1ns/10ps

module async_fifo_properties #(
  parameter int PTR_W = 5
) (
  input logic                        wr_clk,
  input logic                        wr_rst_n,
  input logic                        rd_clk,
  input logic                        rd_rst_n,
  input fifo_status_pkg::wr_status_t wr_status,
  input fifo_status_pkg::rd_status_t rd_status,
  input logic [PTR_W-1:0]            wr_gray,
  input logic [PTR_W-1:0]            rd_gray,
  input logic                        wr_accept,
  input logic                        rd_accept
);

  import fifo_status_pkg::*;

  localparam logic [PTR_W-1:0] PTR_ONE   = {{(PTR_W-1){1'b0}}, 1'b1};
  localparam logic [PTR_W-1:0] DEPTH_LVL = PTR_ONE << (PTR_W - 1);   // Words in the RAM.

  function automatic logic [PTR_W-1:0] to_bin(input logic [PTR_W-1:0] gray);
    ptr_word_t word;
    word = gray2bin(ptr_word_t'(gray));
    return word[PTR_W-1:0];
  endfunction

  full_implies_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |-> wr_status.afull)
    else $error("full is set while afull is clear");

  empty_implies_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |-> rd_status.aempty)
    else $error("empty is set while aempty is clear");

  wr_gray_one_bit: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    ($countones(wr_gray ^ $past(wr_gray)) <= 1) &&
    ((to_bin(wr_gray) - to_bin($past(wr_gray))) <= PTR_ONE))
    else $error("write Gray pointer moved by more than one step");

  rd_gray_one_bit: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    ($countones(rd_gray ^ $past(rd_gray)) <= 1) &&
    ((to_bin(rd_gray) - to_bin($past(rd_gray))) <= PTR_ONE))
    else $error("read Gray pointer moved by more than one step");

  // Measured against the live read pointer, not the synchronized copy.
  no_write_when_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_accept |-> ((to_bin(wr_gray) - to_bin(rd_gray)) < DEPTH_LVL))
    else $error("write accepted while full");

  no_read_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_accept |-> (wr_gray != rd_gray))
    else $error("read accepted while empty");

endmodule

bind async_fifo async_fifo_properties #(
  .PTR_W (ADDR_WIDTH + 1)
) i_fifo_props (
  .wr_clk    (wr_clk),
  .wr_rst_n  (wr_rst_n),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .wr_status (wr_status),
  .rd_status (rd_status),
  .wr_gray   (wr_gray),
  .rd_gray   (rd_gray),
  .wr_accept (wr_accept),
  .rd_accept (rd_accept)
);

// ==== dv/tb_cdc_bridge.sv ====
`timescale 1ns/10ps

module tb_cdc_bridge;

  import cdc_payload_pkg::*;
  import fifo_status_pkg::*;

  localparam int TIMEOUT_CYCLES = 6000;

  logic        wr_clk = 1'b0;
  logic        rd_clk = 1'b0;
  logic        wr_rst_n;
  logic        rd_rst_n;
  logic        sample_wr_en;
  sample_t     sample_wr_data;
  wr_status_t  sample_wr_status;
  logic        sample_rd_en;
  sample_t     sample_rd_data;
  rd_status_t  sample_rd_status;
  logic        ctrl_wr_en;
  ctrl_msg_t   ctrl_wr_data;
  wr_status_t  ctrl_wr_status;
  logic        ctrl_rd_en;
  ctrl_msg_t   ctrl_rd_data;
  rd_status_t  ctrl_rd_status;

  sample_t     sample_q[$];            // Expected read order.
  ctrl_msg_t   ctrl_q[$];
  logic        sample_rd_pend = 1'b0;
  logic        ctrl_rd_pend = 1'b0;
  int          sample_wr_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;
  int          seed = 32'h106e_8687;
  string       test_name = "reset";

  cdc_bridge_top i_dut (.*);

  always #50 rd_clk = ~rd_clk;
  always #35 wr_clk = ~wr_clk;

  // Accepted writes go to the scoreboard with the pre-edge flag.
  always @(posedge wr_clk) begin
    if (wr_rst_n && sample_wr_en && !sample_wr_status.full) begin
      sample_q.push_back(sample_wr_data);
      sample_wr_count++;
    end
    if (wr_rst_n && ctrl_wr_en && !ctrl_wr_status.full) begin
      ctrl_q.push_back(ctrl_wr_data);
    end
  end

  // Read data is due one edge after its accepted read.
  always @(posedge rd_clk) begin
    if (sample_rd_pend) begin
      if (sample_q.size() == 0) begin
        $display("Error in %s: sample read returned data that was never written", test_name);
        error_count++;
      end else begin
        assert (sample_rd_data == sample_q[0])
          else begin
            $display("FAIL %s: expected %h, actual %h", test_name, sample_q[0], sample_rd_data);
            error_count++;
          end
        void'(sample_q.pop_front());
      end
    end
    if (ctrl_rd_pend) begin
      if (ctrl_q.size() == 0) begin
        $display("Error in %s: control read returned data that was never written", test_name);
        error_count++;
      end else begin
        assert (ctrl_rd_data == ctrl_q[0])
          else begin
            $display("FAIL %s: expected %h, actual %h", test_name, ctrl_q[0], ctrl_rd_data);
            error_count++;
          end
        void'(ctrl_q.pop_front());
      end
    end
    sample_rd_pend = rd_rst_n && sample_rd_en && !sample_rd_status.empty;
    ctrl_rd_pend   = rd_rst_n && ctrl_rd_en && !ctrl_rd_status.empty;
  end

  always @(posedge rd_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d read clock cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else begin
        $display("FAIL %s (%s): expected %h, actual %h", test_name, what, exp, act);
        error_count++;
      end
  endtask

  // Flags as {full, afull, empty, aempty}.
  task automatic check_sample_flags(input logic [3:0] exp);
    @(negedge rd_clk);
    check_value("sample flags", 32'(exp), 32'({sample_wr_status, sample_rd_status}));
  endtask

  task automatic write_sample(input sample_t data);
    @(posedge wr_clk);
    sample_wr_en   <= 1'b1;
    sample_wr_data <= data;
    @(posedge wr_clk);
    sample_wr_en   <= 1'b0;
  endtask

  task automatic write_ctrl(input ctrl_msg_t msg);
    @(posedge wr_clk);
    ctrl_wr_en   <= 1'b1;
    ctrl_wr_data <= msg;
    @(posedge wr_clk);
    ctrl_wr_en   <= 1'b0;
  endtask

  function automatic sample_t random_sample();
    logic [31:0] rnd;
    rnd = $random(seed);
    return sample_t'(rnd[20:0]);
  endfunction

  // Reads both streams until every expected word came back.
  task automatic drain_streams();
    @(posedge rd_clk);
    sample_rd_en <= 1'b1;
    ctrl_rd_en   <= 1'b1;
    do begin
      @(negedge rd_clk);
    end while (sample_q.size() != 0 || ctrl_q.size() != 0);
    @(posedge rd_clk);
    sample_rd_en <= 1'b0;
    ctrl_rd_en   <= 1'b0;
    repeat (5) @(posedge rd_clk);
  endtask

  task automatic verify_reset_state();
    test_name = "reset_flags";
    check_sample_flags(4'b0011);
    check_value("ctrl flags", 32'(4'b0011), 32'({ctrl_wr_status, ctrl_rd_status}));
  endtask

  task automatic order_integrity();
    int start_count;
    test_name = "order";
    start_count = sample_wr_count;
    repeat (10) write_sample(random_sample());
    do begin
      @(negedge rd_clk);
    end while (sample_rd_status.empty);
    drain_streams();
    check_value("accepted writes", 32'd10, 32'(sample_wr_count - start_count));
    check_sample_flags(4'b0011);
  endtask

  task automatic full_and_drop();
    int start_count;
    test_name = "full_drop";
    start_count = sample_wr_count;
    for (int i = 0; i < 20 && !sample_wr_status.full; i++) begin
      write_sample(random_sample());
      @(negedge wr_clk);
    end
    repeat (3) write_sample(random_sample());
    @(negedge wr_clk);
    check_value("accepted writes", 32'd16, 32'(sample_wr_count - start_count));
    drain_streams();
    check_sample_flags(4'b0011);
  endtask

  task automatic almost_flag_sweep();
    test_name = "almost_flags";
    for (int level = 1; level <= 16; level++) begin
      write_sample(random_sample());
      repeat (5) @(posedge wr_clk);
      repeat (5) @(posedge rd_clk);
      check_sample_flags({level >= 16, level >= 12, 1'b0, level <= 2});
    end
    for (int level = 15; level >= 0; level--) begin
      @(posedge rd_clk);
      sample_rd_en <= 1'b1;
      @(posedge rd_clk);
      sample_rd_en <= 1'b0;
      repeat (5) @(posedge rd_clk);
      repeat (5) @(posedge wr_clk);
      check_sample_flags({1'b0, level >= 12, level == 0, level <= 2});
    end
  endtask

  task automatic ctrl_stream_alone();
    logic [31:0] rnd;
    test_name = "ctrl_stream";
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      write_ctrl(ctrl_msg_t'(rnd[10:0]));
      check_sample_flags(4'b0011);
    end
    @(negedge wr_clk);
    check_value("ctrl full", 32'd1, 32'(ctrl_wr_status.full));
    drain_streams();
    check_value("ctrl flags", 32'(4'b0011), 32'({ctrl_wr_status, ctrl_rd_status}));
  endtask

  task automatic random_traffic();
    logic [31:0] wr_rnd;
    logic [31:0] rd_rnd;
    logic        done;
    test_name = "random_traffic";
    done = 1'b0;
    fork
      begin
        repeat (300) begin
          @(posedge rd_clk);
          rd_rnd = $random(seed);
          sample_rd_en <= rd_rnd[0];
          ctrl_rd_en   <= rd_rnd[1] & rd_rnd[2];   // Slower message drain.
        end
        done = 1'b1;
      end
      begin
        while (!done) begin
          @(posedge wr_clk);
          wr_rnd = $random(seed);
          sample_wr_en   <= wr_rnd[0];
          sample_wr_data <= sample_t'(wr_rnd[31:11]);
          ctrl_wr_en     <= wr_rnd[1] & wr_rnd[2];
          ctrl_wr_data   <= ctrl_msg_t'(wr_rnd[10:0]);
        end
        sample_wr_en <= 1'b0;
        ctrl_wr_en   <= 1'b0;
      end
    join
    repeat (5) @(posedge wr_clk);
    drain_streams();
    check_sample_flags(4'b0011);
    check_value("ctrl flags", 32'(4'b0011), 32'({ctrl_wr_status, ctrl_rd_status}));
  endtask

  initial begin
    wr_rst_n       = 1'b0;
    rd_rst_n       = 1'b0;
    sample_wr_en   = 1'b0;
    sample_wr_data = '0;
    sample_rd_en   = 1'b0;
    ctrl_wr_en     = 1'b0;
    ctrl_wr_data   = '0;
    ctrl_rd_en     = 1'b0;
    repeat (3) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    repeat (2) @(posedge rd_clk);
    verify_reset_state();
    order_integrity();
    full_and_drop();
    almost_flag_sweep();
    ctrl_stream_alone();
    random_traffic();
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
src/cdc_payload_pkg.sv
src/fifo_status_pkg.sv
src/dual_port_ram.sv
src/wr_ptr_ctrl.sv
src/rd_ptr_ctrl.sv
src/async_fifo.sv
src/cdc_bridge_top.sv
dv/async_fifo_properties.sv
dv/tb_cdc_bridge.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_cdc_bridge -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
else
  exit 1
fi
